//--- src/mem_err_pkg.sv
// Shared widths, record types and the Hamming layout for the memory-error
// logging block. The RTL and the testbench both take their definitions from
// here, so the codeword layout has only one description.
package mem_err_pkg;

   // Physical address width of a memory reference.
   localparam int addr_w = 24;

   // Width of one data word and of the internal data bus.
   localparam int data_w = 16;

   // Check bits per word. Bits 0 to 4 are Hamming bits and bit 5 is the
   // overall parity over the whole 22-bit codeword.
   localparam int chk_w = 6;

   // Width of the error code, which is the Hamming syndrome.
   localparam int code_w = 5;

   // Highest Hamming codeword position. Positions run from 1 to 21 and the
   // overall parity bit sits outside this numbering.
   localparam int cw_last = data_w + chk_w - 1;

   // One returned memory read as it arrives from the memory bus.
   typedef struct packed {
      logic [addr_w-1:0] addr;
      // Set for an instruction fetch, an examine or a deposit.
      logic              fetch;
      logic              dma;
      logic [data_w-1:0] data;
      logic [chk_w-1:0]  check;
   } mem_ref_t;

   // Registered result of the SEC-DED check.
   typedef struct packed {
      logic [addr_w-1:0] addr;
      logic              fetch;
      logic              dma;
      // Data after single-bit correction.
      logic [data_w-1:0] data;
      // Syndrome of the checked word.
      logic [code_w-1:0] code;
      // Multiple-bit error, data left as received.
      logic              fatal;
      // Any error at all in this word.
      logic              err;
   } ecc_result_t;

   // Field layout of the PES register as software sees it.
   typedef struct packed {
      logic                     fetch;
      logic                     dma;
      logic                     fatal;
      logic [code_w-1:0]        code;
      logic [addr_w-data_w-1:0] addr_hi;
   } pes_fields_t;

   // The PES word is loaded field by field but read back as one bus word.
   typedef union packed {
      logic [data_w-1:0] raw;
      pes_fields_t       fields;
   } pes_word_u;

   // Returns the codeword position of data bit idx. Data bits fill the
   // positions that are not a power of two, in ascending order.
   function automatic logic [code_w-1:0] data_pos(input int unsigned idx);
      int unsigned cnt;
      logic [code_w-1:0] pos;
      cnt = 0;
      pos = '0;
      for (int p = 1; p <= cw_last; p++) begin
         // A power of two holds a Hamming check bit, so skip it.
         if ((p & (p - 1)) != 0) begin
            if (cnt == idx) begin
               pos = p[code_w-1:0];
            end
            cnt++;
         end
      end
      return pos;
   endfunction

endpackage

//--- src/ecc_syndrome_check.sv
`timescale 1ns/1ps

// Single pipeline stage of the SEC-DED checker.
// The stage rebuilds the 21-position Hamming codeword from the returned data
// and check bits, computes the syndrome and the overall parity, corrects a
// single flipped bit and flags anything worse as fatal. Results appear one
// cycle after mem_valid and a new read is taken every cycle.
module ecc_syndrome_check (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     mem_valid,
   input  mem_err_pkg::mem_ref_t    mem_ref,
   output logic                     res_valid,
   output mem_err_pkg::ecc_result_t res
);

   // Codeword as received and after correction, indexed by position.
   logic [mem_err_pkg::cw_last:1] cw;
   logic [mem_err_pkg::cw_last:1] cw_fix;

   // Recomputed syndrome and overall parity mismatch.
   logic [mem_err_pkg::code_w-1:0] syn;
   logic par_err;

   // Error class of the incoming word.
   logic single_err;
   logic multi_err;

   // Corrected data taken back out of the codeword.
   logic [mem_err_pkg::data_w-1:0] data_fix;

   // Next result and the registered payload.
   mem_err_pkg::ecc_result_t res_d;
   mem_err_pkg::ecc_result_t res_q;

   // Error flag kept apart from the payload so that it reads low between reads.
   logic err_q;

   // Rebuild the codeword from the check and data bits.
   always_comb begin
      cw = '0;
      // Hamming bit k sits at position 2**k.
      for (int k = 0; k < mem_err_pkg::code_w; k++) begin
         cw[1 << k] = mem_ref.check[k];
      end
      for (int i = 0; i < mem_err_pkg::data_w; i++) begin
         cw[mem_err_pkg::data_pos(i)] = mem_ref.data[i];
      end
   end

   // The syndrome is the XOR of the indices of all set positions. This equals
   // one even-parity check per index bit, with the check bit included.
   always_comb begin
      syn = '0;
      for (int p = 1; p <= mem_err_pkg::cw_last; p++) begin
         if (cw[p]) begin
            syn = syn ^ p[mem_err_pkg::code_w-1:0];
         end
      end
   end

   // Overall parity covers all 22 bits and must come out even.
   assign par_err = ^cw ^ mem_ref.check[mem_err_pkg::chk_w-1];

   // A parity mismatch with a syndrome inside the codeword is one flipped bit.
   // A syndrome of zero then points at the overall parity bit itself.
   assign single_err = par_err && (syn <= mem_err_pkg::cw_last);

   // Even parity with a nonzero syndrome means two flips. A syndrome beyond
   // the last position cannot come from a single flip either.
   assign multi_err = (!par_err && (syn != '0)) ||
                      (par_err && (syn > mem_err_pkg::cw_last));

   // Flip the failing position back. Position 0 is the parity bit, which
   // carries no data and needs no repair here.
   always_comb begin
      cw_fix = cw;
      if (single_err && (syn != '0)) begin
         cw_fix[syn] = ~cw[syn];
      end
      for (int i = 0; i < mem_err_pkg::data_w; i++) begin
         data_fix[i] = cw_fix[mem_err_pkg::data_pos(i)];
      end
   end

   // Assemble the result record for the register stage.
   always_comb begin
      res_d.addr  = mem_ref.addr;
      res_d.fetch = mem_ref.fetch;
      res_d.dma   = mem_ref.dma;
      // Fatal words go out exactly as received.
      res_d.data  = multi_err ? mem_ref.data : data_fix;
      res_d.code  = syn;
      res_d.fatal = multi_err;
      res_d.err   = single_err || multi_err;
   end

   // Valid and error flags are control state and start out low.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         res_valid <= 1'b0;
         err_q     <= 1'b0;
      end else begin
         res_valid <= mem_valid;
         err_q     <= mem_valid && res_d.err;
      end
   end

   // Payload is only loaded when a read arrives.
   always_ff @(posedge clk) begin
      if (mem_valid) begin
         res_q <= res_d;
      end
   end

   // The output record takes its error flag from the reset register.
   always_comb begin
      res     = res_q;
      res.err = err_q;
   end

   // A fatal result must always be reported as an error as well.
   assert property (@(posedge clk) disable iff (!arst_n)
      res_valid |-> (res.err || !res.fatal));

endmodule

//--- src/error_log_ctrl.sv
`timescale 1ns/1ps

// Logging controller for PEA and PES.
// The first error after an unlock is captured into both registers and the
// lock is set. While the lock is set the registers are frozen and err_irq is
// high. Software clears the lock by reading PES.
module error_log_ctrl (
   input  logic clk,
   input  logic arst_n,
   input  logic res_valid,
   input  logic res_err,
   input  logic epes_n,
   output logic spea,
   output logic spes,
   output logic err_irq
);

   // Set while a logged error waits for software.
   logic lock_q;

   // Capture request for the current result cycle.
   logic capture;

   // Capture any valid error result as long as nothing is held.
   assign capture = res_valid && res_err && !lock_q;

   // Both load enables pulse in the same result cycle.
   assign spea = capture;
   assign spes = capture;

   // The lock is set by a capture and cleared by a PES read.
   // A capture in the same cycle as a PES read keeps the lock set, so the
   // new error is never lost.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         lock_q <= 1'b0;
      end else if (capture) begin
         lock_q <= 1'b1;
      end else if (!epes_n) begin
         lock_q <= 1'b0;
      end
   end

   // The interrupt level follows the lock directly.
   assign err_irq = lock_q;

   // No load enable may disturb a logged error.
   assert property (@(posedge clk) disable iff (!arst_n)
      lock_q |-> !(spea || spes));

endmodule

//--- src/pespea_regs.sv
`timescale 1ns/1ps

// PEA and PES diagnostic registers.
// PEA holds the low 16 address bits of the logged error. PES holds the
// reference type, the fatal flag, the error code and the upper address byte.
// Both are read onto the internal data bus through active-low enables.
module pespea_regs (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           spea,
   input  logic                           spes,
   input  logic                           epea_n,
   input  logic                           epes_n,
   input  mem_err_pkg::ecc_result_t       res,
   output logic [mem_err_pkg::data_w-1:0] idb
);

   // Parity error address, low part of the failing address.
   logic [mem_err_pkg::data_w-1:0] pea_q;

   // Parity error status, loaded by field and read back raw.
   mem_err_pkg::pes_word_u pes_q;

   // Both registers read as zero until the first error is logged.
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pea_q     <= '0;
         pes_q.raw <= '0;
      end else begin
         // The address strobe loads PEA and also the PES low byte with the
         // upper address bits, so the full address is captured together.
         if (spea) begin
            pea_q                <= res.addr[mem_err_pkg::data_w-1:0];
            pes_q.fields.addr_hi <= res.addr[mem_err_pkg::addr_w-1:mem_err_pkg::data_w];
         end
         // The status strobe loads the PES high byte.
         if (spes) begin
            pes_q.fields.fetch <= res.fetch;
            pes_q.fields.dma   <= res.dma;
            pes_q.fields.fatal <= res.fatal;
            // For a single error the code names the corrected position.
            pes_q.fields.code  <= res.code;
         end
      end
   end

   // Readback mux onto the internal data bus.
   // The bus is driven with zero when neither register is selected.
   always_comb begin
      if (!epea_n) begin
         idb = pea_q;
      end else if (!epes_n) begin
         idb = pes_q.raw;
      end else begin
         idb = '0;
      end
   end

   // The CPU never selects both registers at once.
   assert property (@(posedge clk) disable iff (!arst_n)
      !(!epea_n && !epes_n));

endmodule

//--- src/mem_err_top.sv
`timescale 1ns/1ps

// Top level of the memory-error logging block.
// A returned read passes through the SEC-DED stage, which corrects it and
// reports errors. The logging controller decides when the error is captured
// into PEA and PES, which the CPU reads over the internal data bus.
module mem_err_top (
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           mem_valid,
   input  logic [mem_err_pkg::addr_w-1:0] mem_addr,
   input  logic                           mem_fetch,
   input  logic                           mem_dma,
   input  logic [mem_err_pkg::data_w-1:0] mem_data,
   input  logic [mem_err_pkg::chk_w-1:0]  mem_check,
   input  logic                           epea_n,
   input  logic                           epes_n,
   output logic                           corr_valid,
   output logic [mem_err_pkg::data_w-1:0] corr_data,
   output logic                           err_flag,
   output logic [mem_err_pkg::data_w-1:0] idb,
   output logic                           err_irq
);

   // Returned read gathered into one record.
   mem_err_pkg::mem_ref_t mem_ref;

   // Registered check result and its strobe.
   mem_err_pkg::ecc_result_t res;
   logic res_valid;

   // Load enables for PEA and PES.
   logic spea;
   logic spes;

   assign mem_ref = '{addr:  mem_addr,
                      fetch: mem_fetch,
                      dma:   mem_dma,
                      data:  mem_data,
                      check: mem_check};

   ecc_syndrome_check u_ecc_syndrome_check (
      .clk       (clk),
      .arst_n    (arst_n),
      .mem_valid (mem_valid),
      .mem_ref   (mem_ref),
      .res_valid (res_valid),
      .res       (res)
   );

   error_log_ctrl u_error_log_ctrl (
      .clk       (clk),
      .arst_n    (arst_n),
      .res_valid (res_valid),
      .res_err   (res.err),
      .epes_n    (epes_n),
      .spea      (spea),
      .spes      (spes),
      .err_irq   (err_irq)
   );

   pespea_regs u_pespea_regs (
      .clk    (clk),
      .arst_n (arst_n),
      .spea   (spea),
      .spes   (spes),
      .epea_n (epea_n),
      .epes_n (epes_n),
      .res    (res),
      .idb    (idb)
   );

   // Corrected read data goes straight back to the CPU side.
   assign corr_valid = res_valid;
   assign corr_data  = res.data;

   // The error flag is only set in a valid result cycle.
   assign err_flag   = res.err;

endmodule

//--- testbench/mem_err_checker.sv
`timescale 1ns/1ps

// Result checker for the memory-error logging block.
// It watches the DUT outputs and keeps its own model of the lock and of the
// values that PEA and PES should hold. The testbench calls in at the falling
// edge, where every output it looks at is stable.
module mem_err_checker (
   input  logic        corr_valid,
   input  logic [15:0] corr_data,
   input  logic        err_flag,
   input  logic [15:0] idb,
   input  logic        err_irq,
   output int          errors
);

   int tests;
   int failed;
   bit test_bad;

   // Lock model. While it is set, no new error may reach PEA or PES.
   bit          locked;
   logic [15:0] exp_pea;
   logic [15:0] exp_pes;

   initial begin
      errors   = 0;
      tests    = 0;
      failed   = 0;
      test_bad = 1'b0;
      locked   = 1'b0;
      exp_pea  = '0;
      exp_pes  = '0;
   end

   task automatic compare(input string name, input string what,
                          input logic [15:0] exp, input logic [15:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s: %s expected 0x%04h, actual 0x%04h", name, what, exp, act);
         errors++;
         test_bad = 1'b1;
      end
   endtask

   task automatic report_problem(input string name, input string msg);
      $display("%s: %s", name, msg);
      errors++;
      test_bad = 1'b1;
   endtask

   // Checks one corrected word and logs it in the model if it should be captured.
   task automatic check_result(input string name, input logic [23:0] addr,
                               input logic fetch, input logic dma,
                               input logic [15:0] data, input logic [15:0] rx_data,
                               input logic [21:0] flips);
      int          nflip;
      logic [4:0]  code;
      logic        fatal;
      nflip = 0;
      code  = '0;
      // The syndrome of any flip pattern is the XOR of the flipped positions.
      for (int j = 0; j < 22; j++) begin
         if (flips[j]) begin
            nflip++;
            code = code ^ j[4:0];
         end
      end
      fatal = (nflip > 1);
      // A fatal word comes back as received, anything else is repaired.
      compare(name, "corr_data", fatal ? rx_data : data, corr_data);
      compare(name, "err_flag", 16'(nflip != 0), 16'(err_flag));
      // The interrupt still shows the lock from before this word.
      compare(name, "err_irq", 16'(locked), 16'(err_irq));
      compare(name, "idle idb", 16'h0000, idb);
      if (nflip != 0 && !locked) begin
         exp_pea = addr[15:0];
         exp_pes = {fetch, dma, fatal, code, addr[23:16]};
         locked  = 1'b1;
      end
   endtask

   // One cycle after a lone result no read is in flight, so both result
   // strobes must read low again.
   task automatic check_pea(input string name);
      compare(name, "corr_valid", 16'h0000, 16'(corr_valid));
      compare(name, "err_flag", 16'h0000, 16'(err_flag));
      compare(name, "PEA", exp_pea, idb);
      compare(name, "err_irq", 16'(locked), 16'(err_irq));
   endtask

   // A PES read releases the lock at the end of the read cycle.
   task automatic check_pes_read(input string name);
      compare(name, "PES", exp_pes, idb);
      locked = 1'b0;
   endtask

   task automatic check_irq(input string name);
      compare(name, "err_irq", 16'(locked), 16'(err_irq));
   endtask

   task automatic end_test(input string name);
      tests++;
      if (test_bad) begin
         failed++;
         $display("FAIL %s", name);
      end else begin
         $display("PASS %s", name);
      end
      test_bad = 1'b0;
   endtask

   task automatic summary();
      $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
   endtask

endmodule

//--- testbench/tb_mem_err.sv
`timescale 1ns/1ps

// Testbench for the memory-error logging block.
// Each table entry is encoded by the Hamming rule, optionally corrupted,
// driven into the DUT and checked, with an optional readback of PEA and PES.
module tb_mem_err;

   // Readback after a result. PEA only leaves the lock set.
   localparam logic [1:0] rd_none = 2'd0;
   localparam logic [1:0] rd_pea  = 2'd1;
   localparam logic [1:0] rd_both = 2'd2;

   // Clock cycles to wait for corr_valid before giving up.
   localparam int result_timeout = 8;

   typedef struct packed {
      logic [23:0] addr;
      logic        fetch;
      logic        dma;
      logic [15:0] data;
      // Bit p flips codeword position p. Bit 0 flips the overall parity bit.
      logic [21:0] flips;
      // Driven in the cycle right after the previous entry.
      logic        b2b;
      logic [1:0]  rd;
   } stim_t;

   logic        clk;
   logic        arst_n;
   logic        mem_valid;
   logic [23:0] mem_addr;
   logic        mem_fetch;
   logic        mem_dma;
   logic [15:0] mem_data;
   logic [5:0]  mem_check;
   logic        epea_n;
   logic        epes_n;
   logic        corr_valid;
   logic [15:0] corr_data;
   logic        err_flag;
   logic [15:0] idb;
   logic        err_irq;
   int          errors;

   stim_t tbl[$];
   string names[$];
   int    seed;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   mem_err_top u_mem_err_top (
      .clk (clk), .arst_n (arst_n), .mem_valid (mem_valid), .mem_addr (mem_addr),
      .mem_fetch (mem_fetch), .mem_dma (mem_dma), .mem_data (mem_data),
      .mem_check (mem_check), .epea_n (epea_n), .epes_n (epes_n),
      .corr_valid (corr_valid), .corr_data (corr_data), .err_flag (err_flag),
      .idb (idb), .err_irq (err_irq)
   );

   mem_err_checker u_mem_err_checker (
      .corr_valid (corr_valid), .corr_data (corr_data), .err_flag (err_flag), .idb (idb),
      .err_irq (err_irq), .errors (errors)
   );

   // Index 0 holds the overall parity bit, indices 1 to 21 the Hamming positions.
   function automatic logic [21:0] encode(input logic [15:0] data);
      logic [21:0] cw;
      int          d;
      cw = '0;
      d  = 0;
      // Data bits fill every position that is not a power of two.
      for (int p = 3; p <= 21; p++) begin
         if ((p & (p - 1)) != 0) begin
            cw[p] = data[d];
            d++;
         end
      end
      // Check bit k gives even parity over the positions with index bit k set.
      for (int k = 0; k < 5; k++) begin
         for (int p = 1; p <= 21; p++) begin
            if (p[k] && p != (1 << k)) begin
               cw[1 << k] = cw[1 << k] ^ cw[p];
            end
         end
      end
      cw[0] = ^cw[21:1];
      return cw;
   endfunction

   // Splits a codeword into the bus form {data, check}.
   function automatic logic [21:0] split_word(input logic [21:0] cw);
      logic [15:0] data;
      logic [5:0]  check;
      int          d;
      d    = 0;
      data = '0;
      for (int p = 3; p <= 21; p++) begin
         if ((p & (p - 1)) != 0) begin
            data[d] = cw[p];
            d++;
         end
      end
      for (int k = 0; k < 5; k++) begin
         check[k] = cw[1 << k];
      end
      check[5] = cw[0];
      return {data, check};
   endfunction

   task automatic add_entry(input string name, input logic [23:0] addr, input logic fetch,
                            input logic dma, input logic [15:0] data,
                            input logic [21:0] flips, input logic b2b, input logic [1:0] rd);
      stim_t s;
      s.addr  = addr;
      s.fetch = fetch;
      s.dma   = dma;
      s.data  = data;
      s.flips = flips;
      s.b2b   = b2b;
      s.rd    = rd;
      tbl.push_back(s);
      names.push_back(name);
   endtask

   // An entry that is followed by a back-to-back entry never reads back.
   task automatic build_table();
      add_entry("clean_fetch", 24'h3a5c71, 1'b1, 1'b0, 16'hbeef, 22'h0, 1'b0, rd_none);
      add_entry("clean_dma", 24'h80f00d, 1'b0, 1'b1, 16'($random(seed)), 22'h0, 1'b0, rd_none);
      for (int p = 0; p < 22; p++) begin
         add_entry($sformatf("single_flip_%0d", p), 24'($random(seed)), p[0], p[1],
                   16'($random(seed)), 22'(1) << p, 1'b0, rd_both);
      end
      add_entry("double_data", 24'h123456, 1'b0, 1'b0, 16'h5a5a, 22'h000028, 1'b0, rd_both);
      add_entry("double_parity", 24'hfedcba, 1'b1, 1'b1, 16'h0ff0, 22'h020001, 1'b0, rd_both);
      add_entry("double_high_syn", 24'h00ffee, 1'b0, 1'b1, 16'hc3a5, 22'h010100, 1'b0, rd_both);
      // The first error locks, the next two must leave PEA and PES alone.
      add_entry("lock_first", 24'h4b0001, 1'b1, 1'b0, 16'h1357, 22'h000040, 1'b0, rd_none);
      add_entry("lock_second", 24'h4b0002, 1'b0, 1'b1, 16'h2468, 22'h000c00, 1'b0, rd_pea);
      add_entry("lock_third", 24'h4b0003, 1'b0, 1'b0, 16'h9abc, 22'h001000, 1'b0, rd_both);
      add_entry("unlock_next", 24'h4b0004, 1'b1, 1'b1, 16'hdef0, 22'h000200, 1'b0, rd_both);
      add_entry("burst_0", 24'h7700a0, 1'b0, 1'b0, 16'($random(seed)), 22'h0, 1'b0, rd_none);
      add_entry("burst_1", 24'h7700a1, 1'b0, 1'b0, 16'($random(seed)), 22'h0, 1'b1, rd_none);
      add_entry("burst_2", 24'h7700a2, 1'b1, 1'b0, 16'($random(seed)), 22'h004000, 1'b1,
                rd_none);
      add_entry("burst_3", 24'h7700a3, 1'b0, 1'b1, 16'($random(seed)), 22'h0, 1'b1, rd_both);
   endtask

   task automatic drive_entry(input stim_t s);
      logic [21:0] word;
      word = split_word(encode(s.data) ^ s.flips);
      mem_valid <= 1'b1;
      mem_addr  <= s.addr;
      mem_fetch <= s.fetch;
      mem_dma   <= s.dma;
      mem_data  <= word[21:6];
      mem_check <= word[5:0];
   endtask

   // PEA is readable one cycle after the result, PES in the cycle after that.
   task automatic read_back(input string name, input logic [1:0] rd);
      if (rd != rd_none) begin
         @(posedge clk);
         epea_n <= 1'b0;
         @(negedge clk);
         u_mem_err_checker.check_pea(name);
         @(posedge clk);
         epea_n <= 1'b1;
         if (rd == rd_both) begin
            epes_n <= 1'b0;
            @(negedge clk);
            u_mem_err_checker.check_pes_read(name);
            @(posedge clk);
            epes_n <= 1'b1;
            @(negedge clk);
            u_mem_err_checker.check_irq(name);
         end
      end
   endtask

   initial begin
      stim_t       s;
      logic [21:0] rx;
      int          cnt;
      arst_n    = 1'b0;
      mem_valid = 1'b0;
      mem_addr  = '0;
      mem_fetch = 1'b0;
      mem_dma   = 1'b0;
      mem_data  = '0;
      mem_check = '0;
      epea_n    = 1'b1;
      epes_n    = 1'b1;
      seed      = 32'hc2f64ce4;
      build_table();
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      for (int i = 0; i < tbl.size(); i++) begin
         s = tbl[i];
         if (!s.b2b) begin
            @(posedge clk);
            drive_entry(s);
         end
         // The DUT takes the word on this edge, so the next word can follow at once.
         @(posedge clk);
         if (i + 1 < tbl.size() && tbl[i + 1].b2b) begin
            drive_entry(tbl[i + 1]);
         end else begin
            mem_valid <= 1'b0;
         end
         cnt = 0;
         @(negedge clk);
         while (!corr_valid && cnt < result_timeout) begin
            @(negedge clk);
            cnt++;
         end
         if (!corr_valid) begin
            u_mem_err_checker.report_problem(names[i], "no corrected result before the timeout");
         end else begin
            if (cnt != 0) begin
               u_mem_err_checker.report_problem(names[i], "corrected result came too late");
            end
            rx = split_word(encode(s.data) ^ s.flips);
            u_mem_err_checker.check_result(names[i], s.addr, s.fetch, s.dma, s.data,
                                           rx[21:6], s.flips);
            read_back(names[i], s.rd);
         end
         u_mem_err_checker.end_test(names[i]);
      end
      repeat (2) @(posedge clk);
      u_mem_err_checker.summary();
      if (errors == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

//--- vlog.f
src/mem_err_pkg.sv
src/ecc_syndrome_check.sv
src/error_log_ctrl.sv
src/pespea_regs.sv
src/mem_err_top.sv
testbench/mem_err_checker.sv
testbench/tb_mem_err.sv

//--- run_sim.sh
#!/bin/sh
# Build the RTL and testbench with Verilator, run the simulation and
# decide pass or fail from what the testbench prints.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_err \
   -f vlog.f -Mdir obj_dir -o tb_mem_err
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_mem_err)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1
